//--- files.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/data_cache.sv
verilog/memory_controller.sv
verilog/memory_stage.sv
verilog/memory_subsystem.sv
testbench/memory_subsystem_tb.sv

//--- testbench/memory_subsystem_input.txt
# Columns are op (0 load, 1 store), byte address, store data, expected load data
# All fields are hex and stores expect zero data
0 00000000 00000000 00000000
0 00000004 00000000 00000001
0 0000003C 00000000 0000000F
1 00000008 DEADBEEF 00000000
0 00000008 00000000 DEADBEEF
0 00000200 00000000 00000080
0 00000008 00000000 DEADBEEF
0 0000000C 00000000 00000003
0 00000100 00000000 00000040
1 00000104 12345678 00000000
1 0000013C CAFEF00D 00000000
0 00000500 00000000 00000140
0 00000104 00000000 12345678
0 0000013C 00000000 CAFEF00D
0 00000108 00000000 00000042
1 00000240 A5A5A5A5 00000000
0 00000240 00000000 A5A5A5A5
1 00000440 5A5A5A5A 00000000
0 00000240 00000000 A5A5A5A5
0 00000440 00000000 5A5A5A5A
0 00000FC0 00000000 000003F0
0 00000FFC 00000000 000003FF
1 00000FFC 0BADF00D 00000000
0 000001C0 00000000 00000070
0 00000FFC 00000000 0BADF00D
0 000000C0 00000000 00000030
0 000000C4 00000000 00000031
1 000000C4 11111111 00000000
1 000000C4 22222222 00000000
0 000000C4 00000000 22222222
0 000002C4 00000000 000000B1
0 000000C4 00000000 22222222
0 00000800 00000000 00000200
0 000007FC 00000000 000001FF
0 000009C0 00000000 00000270

//--- testbench/memory_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module memory_subsystem_tb
    import mem_pkg::*;
();

    localparam int hitLatency = 2;
    localparam int blockShift = $clog2(`BLOCK_WORDS) + 2;

    logic     clk;
    logic     rst;
    logic     reqValid;
    memReq_t  req;
    logic     respValid;
    memResp_t resp;
    logic     stall;

    // Stimulus table with one entry per file line
    bit    opQ[$];
    addr_t addrQ[$];
    word_t dataQ[$];
    word_t expQ[$];

    // Which block each cache line should hold
    logic [`CACHE_LINES-1:0] lineValid;
    addr_t                   lineBlock [`CACHE_LINES];

    int   valueErrors;
    int   otherErrors;
    int   checks;
    int   issued;
    int   pulseCount;
    int   cycleCount;
    int   cycleLimit;
    logic prevResp;

    memory_subsystem UUT (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .req(req),
        .respValid(respValid), .resp(resp), .stall(stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycleCount);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Count response pulses and catch pulses that last two cycles
    always @(negedge clk) begin
        if (!rst) begin
            if (respValid === 1'b1) begin
                pulseCount++;
                if (prevResp === 1'b1) begin
                    $display("[FAIL] respValid second cycle expected 0x0 got 0x%h", respValid);
                    valueErrors++;
                end
            end
            prevResp = respValid;
        end
    end

    task automatic readStimulus();
        int          fd;
        int          n;
        int          c;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("testbench/memory_subsystem_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/memory_subsystem_input.txt");
            otherErrors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%h %h %h %h\n", op, a, d, e);
            if (n == 4) begin
                opQ.push_back(op[0]);
                addrQ.push_back(a);
                dataQ.push_back(d);
                expQ.push_back(e);
            end else begin
                // Skip the rest of a comment line
                c = $fgetc(fd);
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic checkIdleOutputs(input string when);
        checks++;
        if (respValid !== 1'b0) begin
            $display("[FAIL] respValid %s expected 0x0 got 0x%h", when, respValid);
            valueErrors++;
        end
        if (stall !== 1'b0) begin
            $display("[FAIL] stall %s expected 0x0 got 0x%h", when, stall);
            valueErrors++;
        end
        if (resp !== '0) begin
            $display("[FAIL] resp %s expected 0x0 got 0x%h", when, resp);
            valueErrors++;
        end
    endtask

    task automatic runRequest(input int idx);
        int       latency;
        int       lineIdx;
        bit       expectHit;
        bit       done;
        addr_t    blk;
        memResp_t got;
        blk       = addrQ[idx] >> blockShift;
        lineIdx   = blk % `CACHE_LINES;
        expectHit = lineValid[lineIdx] && (lineBlock[lineIdx] == blk);
        @(posedge clk);
        #1;
        // Stage idle and every earlier response counted once
        if (stall !== 1'b0) begin
            $display("[FAIL] stall before request %0d expected 0x0 got 0x%h", idx, stall);
            valueErrors++;
        end
        if (pulseCount != issued) begin
            $display("%0d response pulses for %0d requests before request %0d",
                     pulseCount, issued, idx);
            otherErrors++;
        end
        reqValid   = 1'b1;
        req.read   = !opQ[idx];
        req.write  = opQ[idx];
        req.addr   = addrQ[idx];
        req.data   = dataQ[idx];
        issued++;
        @(posedge clk);
        #1;
        reqValid = 1'b0;
        req      = '0;
        latency  = 1;
        done     = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (stall !== 1'b1) begin
                $display("[FAIL] stall request %0d expected 0x1 got 0x%h", idx, stall);
                valueErrors++;
            end
            if (respValid === 1'b1) begin
                got  = resp;
                done = 1'b1;
            end else begin
                @(posedge clk);
                latency++;
            end
        end
        checks++;
        if (expectHit && latency != hitLatency) begin
            $display("Request %0d should hit but took %0d cycles", idx, latency);
            otherErrors++;
        end
        if (!expectHit && latency <= hitLatency) begin
            $display("Request %0d should miss but took only %0d cycles", idx, latency);
            otherErrors++;
        end
        if (opQ[idx]) begin
            if (got.isLoad !== 1'b0 || got.data !== '0) begin
                $display("[FAIL] resp store %0d expected 0x%h got 0x%h",
                         idx, {32'h0, 1'b0}, got);
                valueErrors++;
            end
        end else begin
            if (got.isLoad !== 1'b1) begin
                $display("[FAIL] resp.isLoad load %0d expected 0x1 got 0x%h", idx, got.isLoad);
                valueErrors++;
            end
            if (got.data !== expQ[idx]) begin
                $display("[FAIL] resp.data load %0d at 0x%h expected 0x%h got 0x%h",
                         idx, addrQ[idx], expQ[idx], got.data);
                valueErrors++;
            end
        end
        lineValid[lineIdx] = 1'b1;
        lineBlock[lineIdx] = blk;
    endtask

    initial begin
        rst         = 1'b1;
        reqValid    = 1'b0;
        req         = '0;
        valueErrors = 0;
        otherErrors = 0;
        checks      = 0;
        issued      = 0;
        pulseCount  = 0;
        cycleCount  = 0;
        cycleLimit  = 0;
        prevResp    = 1'b0;
        lineValid   = '0;
        readStimulus();
        if (opQ.size() == 0) begin
            $display("No requests were read from the stimulus file");
            otherErrors++;
        end
        cycleLimit = opQ.size() * (4 * `MEM_LATENCY + 10) + 50;

        @(posedge clk);
        @(negedge clk);
        checkIdleOutputs("during reset");
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checkIdleOutputs("after reset");

        for (int i = 0; i < opQ.size(); i++) begin
            runRequest(i);
        end

        // Watch a quiet bus for late pulses
        repeat (5) @(posedge clk);
        #1;
        if (pulseCount != issued) begin
            $display("%0d response pulses seen for %0d requests", pulseCount, issued);
            otherErrors++;
        end

        $display("Requests %0d, checks %0d, value errors %0d, other errors %0d",
                 issued, checks, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/data_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module data_cache
    import mem_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    input  addr_t  addr,
    input  word_t  wrData,
    input  block_t blkIn,
    input  logic   rd,
    input  logic   wr,
    input  logic   ld,

    output logic   hit,
    output logic   dirty,
    output word_t  rdData,
    output block_t victimBlk,
    output addr_t  victimAddr
);

    localparam int byteBits   = 2;
    localparam int offsetBits = $clog2(`BLOCK_WORDS);
    localparam int indexBits  = $clog2(`CACHE_LINES);
    localparam int tagBits    = `DATA_WIDTH - indexBits - offsetBits - byteBits;

    // Per-line state
    logic [`CACHE_LINES-1:0] validBits;
    logic [`CACHE_LINES-1:0] dirtyBits;
    logic [tagBits-1:0]      tagArr [`CACHE_LINES];
    block_t                  dataArr [`CACHE_LINES];

    // Address fields
    logic [offsetBits-1:0] offset;
    logic [indexBits-1:0]  index;
    logic [tagBits-1:0]    tag;
    logic                  tagMatch;
    logic                  writeHit;

    assign offset = addr[byteBits +: offsetBits];
    assign index  = addr[byteBits+offsetBits +: indexBits];
    assign tag    = addr[`DATA_WIDTH-1 -: tagBits];

    // Lookup is purely combinational on addr
    assign tagMatch = (tagArr[index] == tag);
    assign hit      = validBits[index] && tagMatch;

    // Dirty only matters when the line is about to be replaced
    assign dirty    = validBits[index] && dirtyBits[index] && !tagMatch;
    assign writeHit = wr && hit;

    assign rdData = (rd && hit) ? dataArr[index][offset*`DATA_WIDTH +: `DATA_WIDTH] : '0;

    // Victim block and the block address it came from
    assign victimBlk  = dataArr[index];
    assign victimAddr = {tagArr[index], index, {(offsetBits + byteBits){1'b0}}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else begin
            if (ld) begin
                // Refilled line is clean
                validBits[index] <= 1'b1;
                dirtyBits[index] <= 1'b0;
            end else if (writeHit) begin
                dirtyBits[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld) begin
            tagArr[index]  <= tag;
            dataArr[index] <= blkIn;
        end else if (writeHit) begin
            dataArr[index][offset*`DATA_WIDTH +: `DATA_WIDTH] <= wrData;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Width of a data word and of a byte address
`define DATA_WIDTH 32

// Words per cache block, 512 bits in total
`define BLOCK_WORDS 16

// Direct-mapped cache lines, power of two
`define CACHE_LINES 8

// Blocks held by the backing store, power of two
`define MEM_BLOCKS 64

// Cycles from a transfer start strobe to its done strobe, at least 2
`define MEM_LATENCY 4

`endif

//--- verilog/mem_pkg.sv
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

    // Plain vectors with a meaning of their own
    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [`DATA_WIDTH-1:0] addr_t;
    typedef logic [`DATA_WIDTH*`BLOCK_WORDS-1:0] block_t;

    // One processor-side request
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        word_t data;
    } memReq_t;

    // Response, data is zero for a store
    typedef struct packed {
        word_t data;
        logic  isLoad;
    } memResp_t;

    // Memory stage FSM
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        EVICT  = 3'd2,
        FETCH  = 3'd3,
        REFILL = 3'd4
    } stageState_t;

endpackage

`default_nettype wire

//--- verilog/memory_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module memory_controller
    import mem_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    input  logic   fetchStart,
    input  addr_t  fetchAddr,
    input  logic   evictStart,
    input  addr_t  evictAddr,
    input  block_t evictBlk,

    output logic   fetchValid,
    output block_t fetchBlk,
    output logic   evictDone
);

    localparam int blkLsb     = $clog2(`BLOCK_WORDS) + 2;
    localparam int blkIdxBits = $clog2(`MEM_BLOCKS);
    localparam int cntBits    = $clog2(`MEM_LATENCY + 1);

    block_t backing [`MEM_BLOCKS];

    // One transfer in flight at a time
    logic                  busy;
    logic                  isEvict;
    logic [cntBits-1:0]    cnt;
    logic                  finish;
    logic [blkIdxBits-1:0] pendIdx;
    block_t                pendBlk;

    assign finish = busy && (cnt == cntBits'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            isEvict    <= 1'b0;
            cnt        <= '0;
            fetchValid <= 1'b0;
            evictDone  <= 1'b0;
        end else begin
            fetchValid <= 1'b0;
            evictDone  <= 1'b0;
            if (!busy) begin
                if (evictStart || fetchStart) begin
                    busy    <= 1'b1;
                    isEvict <= evictStart;
                    cnt     <= cntBits'(`MEM_LATENCY - 1);
                end
            end else if (finish) begin
                busy       <= 1'b0;
                fetchValid <= !isEvict;
                evictDone  <= isEvict;
            end else begin
                cnt <= cnt - cntBits'(1);
            end
        end
    end

    // Latch the transfer and present the fetched block at the end
    always_ff @(posedge clk) begin
        if (!busy && evictStart) begin
            pendIdx <= evictAddr[blkLsb +: blkIdxBits];
            pendBlk <= evictBlk;
        end else if (!busy && fetchStart) begin
            pendIdx <= fetchAddr[blkLsb +: blkIdxBits];
        end
        if (finish && !isEvict) begin
            fetchBlk <= backing[pendIdx];
        end
    end

    // Backing store comes out of reset with each word holding its word index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int b = 0; b < `MEM_BLOCKS; b++) begin
                for (int w = 0; w < `BLOCK_WORDS; w++) begin
                    backing[b][w*`DATA_WIDTH +: `DATA_WIDTH] <= word_t'(b*`BLOCK_WORDS + w);
                end
            end
        end else if (finish && isEvict) begin
            backing[pendIdx] <= pendBlk;
        end
    end

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module memory_stage
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     reqValid,
    input  memReq_t  req,
    output logic     respValid,
    output memResp_t resp,
    output logic     stall,

    // Cache side
    output addr_t    cacheAddr,
    output word_t    cacheWrData,
    output block_t   cacheBlkIn,
    output logic     cacheRd,
    output logic     cacheWr,
    output logic     cacheLd,
    input  logic     hit,
    input  logic     dirty,
    input  word_t    rdData,
    input  block_t   victimBlk,
    input  addr_t    victimAddr,

    // Memory controller side
    output logic     fetchStart,
    output addr_t    fetchAddr,
    output logic     evictStart,
    output addr_t    evictAddr,
    output block_t   evictBlk,
    input  logic     fetchValid,
    input  block_t   fetchBlk,
    input  logic     evictDone
);

    localparam int blkLsb = $clog2(`BLOCK_WORDS) + 2;

    stageState_t state;
    memReq_t     reqReg;
    block_t      fillBlk;
    logic        accept;

    // Busy until the response cycle, inclusive
    assign stall  = (state != IDLE) || respValid;
    assign accept = reqValid && !stall;

    // Cache always looks at the held request
    assign cacheAddr   = reqReg.addr;
    assign cacheWrData = reqReg.data;
    assign cacheBlkIn  = fillBlk;
    assign cacheRd     = (state == LOOKUP) && reqReg.read;
    assign cacheWr     = (state == LOOKUP) && reqReg.write;
    assign cacheLd     = (state == REFILL);

    // Victim stays put until the refill, so it can go straight out
    assign evictAddr = victimAddr;
    assign evictBlk  = victimBlk;
    assign fetchAddr = {reqReg.addr[`DATA_WIDTH-1:blkLsb], {blkLsb{1'b0}}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            respValid  <= 1'b0;
            resp       <= '0;
            fetchStart <= 1'b0;
            evictStart <= 1'b0;
        end else begin
            respValid  <= 1'b0;
            fetchStart <= 1'b0;
            evictStart <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        // rdData is already zero when this is a store
                        respValid   <= 1'b1;
                        resp.data   <= rdData;
                        resp.isLoad <= reqReg.read;
                        state       <= IDLE;
                    end else if (dirty) begin
                        evictStart <= 1'b1;
                        state      <= EVICT;
                    end else begin
                        fetchStart <= 1'b1;
                        state      <= FETCH;
                    end
                end
                EVICT: begin
                    if (evictDone) begin
                        fetchStart <= 1'b1;
                        state      <= FETCH;
                    end
                end
                FETCH: begin
                    if (fetchValid) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    // Replay the access, it hits this time
                    state <= LOOKUP;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqReg <= req;
        end
        if ((state == FETCH) && fetchValid) begin
            fillBlk <= fetchBlk;
        end
    end

endmodule

`default_nettype wire

//--- verilog/memory_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memory_subsystem
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     reqValid,
    input  memReq_t  req,
    output logic     respValid,
    output memResp_t resp,
    output logic     stall
);

    // Stage to cache
    addr_t  cacheAddr;
    word_t  cacheWrData;
    block_t cacheBlkIn;
    logic   cacheRd;
    logic   cacheWr;
    logic   cacheLd;
    logic   hit;
    logic   dirty;
    word_t  rdData;
    block_t victimBlk;
    addr_t  victimAddr;

    // Stage to memory controller
    logic   fetchStart;
    addr_t  fetchAddr;
    logic   evictStart;
    addr_t  evictAddr;
    block_t evictBlk;
    logic   fetchValid;
    block_t fetchBlk;
    logic   evictDone;

    memory_stage iStage (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .req(req),
        .respValid(respValid), .resp(resp), .stall(stall),
        .cacheAddr(cacheAddr), .cacheWrData(cacheWrData), .cacheBlkIn(cacheBlkIn),
        .cacheRd(cacheRd), .cacheWr(cacheWr), .cacheLd(cacheLd),
        .hit(hit), .dirty(dirty), .rdData(rdData),
        .victimBlk(victimBlk), .victimAddr(victimAddr),
        .fetchStart(fetchStart), .fetchAddr(fetchAddr),
        .evictStart(evictStart), .evictAddr(evictAddr), .evictBlk(evictBlk),
        .fetchValid(fetchValid), .fetchBlk(fetchBlk), .evictDone(evictDone)
    );

    data_cache iCache (
        .clk(clk), .rst(rst),
        .addr(cacheAddr), .wrData(cacheWrData), .blkIn(cacheBlkIn),
        .rd(cacheRd), .wr(cacheWr), .ld(cacheLd),
        .hit(hit), .dirty(dirty), .rdData(rdData),
        .victimBlk(victimBlk), .victimAddr(victimAddr)
    );

    memory_controller iMemCtrl (
        .clk(clk), .rst(rst),
        .fetchStart(fetchStart), .fetchAddr(fetchAddr),
        .evictStart(evictStart), .evictAddr(evictAddr), .evictBlk(evictBlk),
        .fetchValid(fetchValid), .fetchBlk(fetchBlk), .evictDone(evictDone)
    );

endmodule

`default_nettype wire
